//--- logic/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

	localparam int DATA_W = 32;

	// load kinds encoded as in the decode stage
	typedef enum logic [2:0] {
		LOAD_NONE = 3'd0,
		LOAD_LB   = 3'd1,
		LOAD_LH   = 3'd2,
		LOAD_LW   = 3'd3,
		LOAD_LBU  = 3'd4,
		LOAD_LHU  = 3'd5
	} load_type_e;

	typedef enum logic [1:0] {
		STORE_NONE = 2'd0,
		STORE_SB   = 2'd1,
		STORE_SH   = 2'd2,
		STORE_SW   = 2'd3
	} store_type_e;

	// one operation from the execute stage
	typedef struct packed {
		logic [DATA_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
		load_type_e        load_type;
		store_type_e       store_type;
		logic [4:0]        rd;
		logic              wen;
	} lsu_req_t;

	typedef struct packed {
		logic              wen;
		logic [4:0]        rd;
		logic [DATA_W-1:0] data;
		logic              err;
	} lsu_wb_t;

	// axi-lite channel payloads
	typedef struct packed {
		logic [DATA_W-1:0] addr;
	} axi_ar_t;

	typedef struct packed {
		logic [DATA_W-1:0] addr;
	} axi_aw_t;

	typedef struct packed {
		logic [DATA_W-1:0]   data;
		logic [DATA_W/8-1:0] strb;
	} axi_w_t;

	typedef struct packed {
		logic [DATA_W-1:0] data;
		logic [1:0]        resp;
	} axi_r_t;

	typedef struct packed {
		logic [1:0] resp;
	} axi_b_t;

	localparam logic [1:0] AXI_RESP_OKAY   = 2'b00;
	localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

//--- logic/store_align.sv
`default_nettype none

module store_align
	import lsu_pkg::*;
(
	input  lsu_req_t req_i,
	output axi_w_t   w_o,
	output logic     misaligned_o
);

	logic [1:0] offset;

	assign offset = req_i.addr[1:0];

	always_comb begin
		w_o          = '0;
		misaligned_o = 1'b0;
		case (req_i.store_type)
			STORE_SB: begin
				// byte copied into every lane with the strobe picking one
				w_o.data = {4{req_i.wdata[7:0]}};
				w_o.strb = 4'b0001 << offset;
			end
			STORE_SH: begin
				w_o.data     = {2{req_i.wdata[15:0]}};
				w_o.strb     = offset[1] ? 4'b1100 : 4'b0011;
				misaligned_o = offset[0];
			end
			STORE_SW: begin
				w_o.data     = req_i.wdata;
				w_o.strb     = 4'b1111;
				misaligned_o = |offset;
			end
			default: begin
				w_o.data = '0;
				w_o.strb = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- logic/load_extract.sv
`default_nettype none

module load_extract
	import lsu_pkg::*;
(
	input  lsu_req_t          req_i,
	input  logic [DATA_W-1:0] rdata_i,
	output logic [DATA_W-1:0] data_o,
	output logic              misaligned_o
);

	logic [1:0]  offset;
	logic [7:0]  byte_sel;
	logic [15:0] half_sel;

	assign offset   = req_i.addr[1:0];
	assign byte_sel = rdata_i[{offset, 3'b000} +: 8];
	assign half_sel = offset[1] ? rdata_i[31:16] : rdata_i[15:0];

	always_comb begin
		data_o       = '0;
		misaligned_o = 1'b0;
		case (req_i.load_type)
			LOAD_LB: begin
				data_o = {{24{byte_sel[7]}}, byte_sel};
			end
			LOAD_LBU: begin
				data_o = {24'b0, byte_sel};
			end
			LOAD_LH: begin
				data_o       = {{16{half_sel[15]}}, half_sel};
				misaligned_o = offset[0];
			end
			LOAD_LHU: begin
				data_o       = {16'b0, half_sel};
				misaligned_o = offset[0];
			end
			LOAD_LW: begin
				data_o       = rdata_i;
				misaligned_o = |offset;
			end
			default: begin
				data_o = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- logic/lsu_ctrl.sv
`default_nettype none

module lsu_ctrl
	import lsu_pkg::*;
(
	input  logic              clk,
	input  logic              rstn,
	input  logic              op_valid_i,
	input  lsu_req_t          op_i,
	output logic              busy_o,
	output logic              wb_valid_o,
	output lsu_wb_t           wb_o,
	output lsu_req_t          req_o,
	input  axi_w_t            st_w_i,
	input  logic              st_misaligned_i,
	input  logic [DATA_W-1:0] ld_data_i,
	input  logic              ld_misaligned_i,
	output logic [DATA_W-1:0] ld_raw_o,
	output axi_ar_t           ar_o,
	output logic              ar_valid_o,
	input  logic              ar_ready_i,
	input  axi_r_t            r_i,
	input  logic              r_valid_i,
	output logic              r_ready_o,
	output axi_aw_t           aw_o,
	output logic              aw_valid_o,
	input  logic              aw_ready_i,
	output axi_w_t            w_o,
	output logic              w_valid_o,
	input  logic              w_ready_i,
	input  axi_b_t            b_i,
	input  logic              b_valid_i,
	output logic              b_ready_o
);

	typedef enum logic [1:0] {
		S_IDLE = 2'd0,
		S_ADDR = 2'd1,
		S_RESP = 2'd2,
		S_DONE = 2'd3
	} state_e;

	state_e            state_q;
	state_e            state_d;
	lsu_req_t          req_q;
	logic [DATA_W-1:0] rdata_q;
	logic              err_q;
	logic              aw_done_q;
	logic              w_done_q;
	logic              is_load;
	logic              is_store;
	logic              is_mem;
	logic              misaligned;
	logic              ar_fire;
	logic              aw_fire;
	logic              w_fire;
	logic              r_fire;
	logic              b_fire;

	// a load wins if both kinds are set
	assign is_load    = req_q.load_type != LOAD_NONE;
	assign is_store   = (req_q.store_type != STORE_NONE) && !is_load;
	assign is_mem     = is_load || is_store;
	assign misaligned = is_load ? ld_misaligned_i : (is_store && st_misaligned_i);

	assign ar_valid_o = (state_q == S_ADDR) && is_load && !misaligned;
	assign aw_valid_o = (state_q == S_ADDR) && is_store && !misaligned && !aw_done_q;
	assign w_valid_o  = (state_q == S_ADDR) && is_store && !misaligned && !w_done_q;
	assign r_ready_o  = (state_q == S_RESP) && is_load;
	assign b_ready_o  = (state_q == S_RESP) && is_store;

	assign ar_fire = ar_valid_o && ar_ready_i;
	assign aw_fire = aw_valid_o && aw_ready_i;
	assign w_fire  = w_valid_o && w_ready_i;
	assign r_fire  = r_valid_i && r_ready_o;
	assign b_fire  = b_valid_i && b_ready_o;

	assign ar_o.addr = req_q.addr;
	assign aw_o.addr = req_q.addr;
	assign w_o       = st_w_i;
	assign req_o     = req_q;
	assign ld_raw_o  = rdata_q;

	assign busy_o     = state_q != S_IDLE;
	assign wb_valid_o = state_q == S_DONE;

	always_comb begin
		state_d = state_q;
		case (state_q)
			S_IDLE: begin
				if (op_valid_i) begin
					state_d = S_ADDR;
				end
			end
			S_ADDR: begin
				if (!is_mem || misaligned) begin
					state_d = S_DONE;
				end else if (is_load && ar_fire) begin
					state_d = S_RESP;
				end else if (is_store && (aw_done_q || aw_fire) && (w_done_q || w_fire)) begin
					state_d = S_RESP;
				end
			end
			S_RESP: begin
				if (r_fire || b_fire) begin
					state_d = S_DONE;
				end
			end
			default: begin
				state_d = S_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state_q <= S_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// aw and w may complete in different cycles
	always_ff @(posedge clk) begin
		if (!rstn || state_q != S_ADDR) begin
			aw_done_q <= 1'b0;
			w_done_q  <= 1'b0;
		end else begin
			if (aw_fire) begin
				aw_done_q <= 1'b1;
			end
			if (w_fire) begin
				w_done_q <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state_q == S_IDLE && op_valid_i) begin
			req_q <= op_i;
		end
		if (r_fire) begin
			rdata_q <= r_i.data;
			err_q   <= r_i.resp != AXI_RESP_OKAY;
		end else if (b_fire) begin
			err_q <= b_i.resp != AXI_RESP_OKAY;
		end
	end

	always_comb begin
		wb_o      = '0;
		wb_o.rd   = req_q.rd;
		if (!is_mem) begin
			// alu result goes straight through
			wb_o.wen  = req_q.wen;
			wb_o.data = req_q.addr;
		end else if (misaligned) begin
			wb_o.err = 1'b1;
		end else if (is_load) begin
			if (err_q) begin
				wb_o.err = 1'b1;
			end else begin
				wb_o.wen  = req_q.wen;
				wb_o.data = ld_data_i;
			end
		end else begin
			// stores never write a register
			wb_o.err = err_q;
		end
	end

	a_ar_hold: assert property (@(posedge clk) disable iff (!rstn)
		ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_o));
	a_aw_hold: assert property (@(posedge clk) disable iff (!rstn)
		aw_valid_o && !aw_ready_i |=> aw_valid_o && $stable(aw_o));
	a_w_hold: assert property (@(posedge clk) disable iff (!rstn)
		w_valid_o && !w_ready_i |=> w_valid_o && $stable(w_o));
	// upstream must wait for busy_o to drop
	a_no_op_busy: assert property (@(posedge clk) disable iff (!rstn)
		op_valid_i |-> !busy_o);

endmodule

`default_nettype wire

//--- logic/axi_lite_ram.sv
`default_nettype none

module axi_lite_ram
	import lsu_pkg::*;
#(
	parameter int RAM_WORDS   = 256,
	parameter int READY_DELAY = 2
) (
	input  logic    clk,
	input  logic    rstn,
	input  axi_ar_t ar_i,
	input  logic    ar_valid_i,
	output logic    ar_ready_o,
	output axi_r_t  r_o,
	output logic    r_valid_o,
	input  logic    r_ready_i,
	input  axi_aw_t aw_i,
	input  logic    aw_valid_i,
	output logic    aw_ready_o,
	input  axi_w_t  w_i,
	input  logic    w_valid_i,
	output logic    w_ready_o,
	output axi_b_t  b_o,
	output logic    b_valid_o,
	input  logic    b_ready_i
);

	localparam int IDX_W = $clog2(RAM_WORDS);
	localparam int CNT_W = (READY_DELAY > 0) ? $clog2(READY_DELAY + 1) : 1;

	logic [DATA_W-1:0] mem [RAM_WORDS];
	logic [CNT_W-1:0]  rd_cnt;
	logic [CNT_W-1:0]  wr_cnt;
	logic              rd_wait_done;
	logic              wr_wait_done;
	logic              ar_fire;
	logic              wr_fire;
	logic [IDX_W-1:0]  rd_idx;
	logic [IDX_W-1:0]  wr_idx;

	function automatic logic in_range(input logic [DATA_W-1:0] addr);
		return (addr >> 2) < RAM_WORDS;
	endfunction

	assign rd_idx = ar_i.addr[IDX_W+1:2];
	assign wr_idx = aw_i.addr[IDX_W+1:2];

	assign rd_wait_done = rd_cnt == CNT_W'(READY_DELAY);
	assign wr_wait_done = wr_cnt == CNT_W'(READY_DELAY);

	// read side
	assign ar_ready_o = ar_valid_i && rd_wait_done && !r_valid_o;
	assign ar_fire    = ar_valid_i && ar_ready_o;

	always_ff @(posedge clk) begin
		if (!rstn || ar_fire) begin
			rd_cnt <= '0;
		end else if (ar_valid_i && !rd_wait_done) begin
			rd_cnt <= rd_cnt + CNT_W'(1);
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			r_valid_o <= 1'b0;
		end else if (ar_fire) begin
			r_valid_o <= 1'b1;
		end else if (r_ready_i) begin
			r_valid_o <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (ar_fire) begin
			r_o.data <= in_range(ar_i.addr) ? mem[rd_idx] : '0;
			r_o.resp <= in_range(ar_i.addr) ? AXI_RESP_OKAY : AXI_RESP_SLVERR;
		end
	end

	// write side takes address and data in the same cycle
	assign aw_ready_o = aw_valid_i && w_valid_i && wr_wait_done && !b_valid_o;
	assign w_ready_o  = aw_ready_o;
	assign wr_fire    = aw_ready_o;

	always_ff @(posedge clk) begin
		if (!rstn || wr_fire) begin
			wr_cnt <= '0;
		end else if ((aw_valid_i || w_valid_i) && !wr_wait_done) begin
			wr_cnt <= wr_cnt + CNT_W'(1);
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			b_valid_o <= 1'b0;
		end else if (wr_fire) begin
			b_valid_o <= 1'b1;
		end else if (b_ready_i) begin
			b_valid_o <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_fire) begin
			b_o.resp <= in_range(aw_i.addr) ? AXI_RESP_OKAY : AXI_RESP_SLVERR;
		end
	end

	// byte lanes only for words that exist
	always_ff @(posedge clk) begin
		if (wr_fire && in_range(aw_i.addr)) begin
			for (int i = 0; i < DATA_W / 8; i++) begin
				if (w_i.strb[i]) begin
					mem[wr_idx][8*i +: 8] <= w_i.data[8*i +: 8];
				end
			end
		end
	end

	a_r_hold: assert property (@(posedge clk) disable iff (!rstn)
		r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_o));
	a_b_hold: assert property (@(posedge clk) disable iff (!rstn)
		b_valid_o && !b_ready_i |=> b_valid_o && $stable(b_o));

endmodule

`default_nettype wire

//--- logic/mem_stage_top.sv
`default_nettype none

module mem_stage_top
	import lsu_pkg::*;
#(
	parameter int RAM_WORDS   = 256,
	parameter int READY_DELAY = 2
) (
	input  logic     clk,
	input  logic     rstn,
	input  logic     op_valid_i,
	input  lsu_req_t op_i,
	output logic     busy_o,
	output logic     wb_valid_o,
	output lsu_wb_t  wb_o
);

	lsu_req_t          req;
	axi_w_t            st_w;
	logic              st_misaligned;
	logic [DATA_W-1:0] ld_data;
	logic              ld_misaligned;
	logic [DATA_W-1:0] ld_raw;
	axi_ar_t           ar;
	logic              ar_valid;
	logic              ar_ready;
	axi_r_t            r;
	logic              r_valid;
	logic              r_ready;
	axi_aw_t           aw;
	logic              aw_valid;
	logic              aw_ready;
	axi_w_t            w;
	logic              w_valid;
	logic              w_ready;
	axi_b_t            b;
	logic              b_valid;
	logic              b_ready;

	lsu_ctrl lsu_ctrl_inst (
		.clk             (clk),
		.rstn            (rstn),
		.op_valid_i      (op_valid_i),
		.op_i            (op_i),
		.busy_o          (busy_o),
		.wb_valid_o      (wb_valid_o),
		.wb_o            (wb_o),
		.req_o           (req),
		.st_w_i          (st_w),
		.st_misaligned_i (st_misaligned),
		.ld_data_i       (ld_data),
		.ld_misaligned_i (ld_misaligned),
		.ld_raw_o        (ld_raw),
		.ar_o            (ar),
		.ar_valid_o      (ar_valid),
		.ar_ready_i      (ar_ready),
		.r_i             (r),
		.r_valid_i       (r_valid),
		.r_ready_o       (r_ready),
		.aw_o            (aw),
		.aw_valid_o      (aw_valid),
		.aw_ready_i      (aw_ready),
		.w_o             (w),
		.w_valid_o       (w_valid),
		.w_ready_i       (w_ready),
		.b_i             (b),
		.b_valid_i       (b_valid),
		.b_ready_o       (b_ready)
	);

	store_align store_align_inst (
		.req_i        (req),
		.w_o          (st_w),
		.misaligned_o (st_misaligned)
	);

	load_extract load_extract_inst (
		.req_i        (req),
		.rdata_i      (ld_raw),
		.data_o       (ld_data),
		.misaligned_o (ld_misaligned)
	);

	axi_lite_ram #(
		.RAM_WORDS   (RAM_WORDS),
		.READY_DELAY (READY_DELAY)
	) axi_lite_ram_inst (
		.clk        (clk),
		.rstn       (rstn),
		.ar_i       (ar),
		.ar_valid_i (ar_valid),
		.ar_ready_o (ar_ready),
		.r_o        (r),
		.r_valid_o  (r_valid),
		.r_ready_i  (r_ready),
		.aw_i       (aw),
		.aw_valid_i (aw_valid),
		.aw_ready_o (aw_ready),
		.w_i        (w),
		.w_valid_i  (w_valid),
		.w_ready_o  (w_ready),
		.b_o        (b),
		.b_valid_o  (b_valid),
		.b_ready_i  (b_ready)
	);

endmodule

`default_nettype wire

//--- tb/mem_stage_tb.sv
`default_nettype none

module mem_stage_tb
	import lsu_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int RAM_WORDS   = 256;
	localparam int READY_DELAY = 2;
	localparam int WAIT_LIMIT  = 100;

	logic     clk;
	logic     rstn;
	logic     op_valid_i;
	lsu_req_t op_i;
	logic     busy_o;
	logic     wb_valid_o;
	lsu_wb_t  wb_o;

	// byte-wide mirror of the ram contents
	logic [7:0]  ref_mem [RAM_WORDS*4];
	logic [15:0] lfsr;
	logic [31:0] word_addrs [6] = '{32'h0, 32'h4, 32'h40, 32'h1f0, 32'h200, 32'h3fc};

	mem_stage_top #(
		.RAM_WORDS   (RAM_WORDS),
		.READY_DELAY (READY_DELAY)
	) mem_stage_top_inst (
		.clk        (clk),
		.rstn       (rstn),
		.op_valid_i (op_valid_i),
		.op_i       (op_i),
		.busy_o     (busy_o),
		.wb_valid_o (wb_valid_o),
		.wb_o       (wb_o)
	);

	always #4 clk = ~clk;

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			fail_run($sformatf("mismatch %s: got 0x%08h expected 0x%08h", name, got, exp));
		end
	endtask

	// taps 16, 14, 13, 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v    = {v[30:0], lfsr[15]};
		end
	endtask

	function automatic lsu_req_t make_req(input logic [31:0] addr, input logic [31:0] wdata,
			input load_type_e lt, input store_type_e st, input logic [4:0] rd);
		lsu_req_t r;
		r.addr       = addr;
		r.wdata      = wdata;
		r.load_type  = lt;
		r.store_type = st;
		r.rd         = rd;
		r.wen        = 1'b1;
		return r;
	endfunction

	// little-endian view of the mirror extended per load kind
	function automatic logic [31:0] expect_load(input logic [31:0] addr, input load_type_e lt);
		int         a;
		logic [7:0] b0;
		logic [7:0] b1;
		a  = int'(addr);
		b0 = ref_mem[a];
		b1 = ref_mem[a+1];
		case (lt)
			LOAD_LB:  return {{24{b0[7]}}, b0};
			LOAD_LBU: return {24'h0, b0};
			LOAD_LH:  return {{16{b1[7]}}, b1, b0};
			LOAD_LHU: return {16'h0, b1, b0};
			default:  return {ref_mem[a+3], ref_mem[a+2], b1, b0};
		endcase
	endfunction

	task automatic model_store(input logic [31:0] addr, input logic [31:0] data,
			input store_type_e st);
		int a;
		a = int'(addr);
		ref_mem[a] = data[7:0];
		if (st != STORE_SB) begin
			ref_mem[a+1] = data[15:8];
		end
		if (st == STORE_SW) begin
			ref_mem[a+2] = data[23:16];
			ref_mem[a+3] = data[31:24];
		end
	endtask

	// one strobe and a wait for the writeback pulse
	task automatic do_op(input lsu_req_t req, output lsu_wb_t wb, output int cycles);
		@(negedge clk);
		check("busy_o", 32'(busy_o), 32'h0);
		check("wb_valid_o", 32'(wb_valid_o), 32'h0);
		op_valid_i = 1'b1;
		op_i       = req;
		cycles     = 0;
		do begin
			@(negedge clk);
			op_valid_i = 1'b0;
			cycles++;
			check("busy_o", 32'(busy_o), 32'h1);
		end while (!wb_valid_o && cycles < WAIT_LIMIT);
		if (!wb_valid_o) begin
			fail_run($sformatf("no writeback within %0d cycles for address 0x%08h",
				WAIT_LIMIT, req.addr));
		end
		wb = wb_o;
	endtask

	task automatic store_and_check(input logic [31:0] addr, input logic [31:0] data,
			input store_type_e st);
		lsu_wb_t wb;
		int      cycles;
		do_op(make_req(addr, data, LOAD_NONE, st, 5'd7), wb, cycles);
		check("wb.err", 32'(wb.err), 32'h0);
		check("wb.wen", 32'(wb.wen), 32'h0);
		model_store(addr, data, st);
	endtask

	task automatic load_and_check(input logic [31:0] addr, input load_type_e lt,
			input logic [4:0] rd);
		lsu_wb_t wb;
		int      cycles;
		do_op(make_req(addr, 32'h0, lt, STORE_NONE, rd), wb, cycles);
		check("wb.err", 32'(wb.err), 32'h0);
		check("wb.wen", 32'(wb.wen), 32'h1);
		check("wb.rd", 32'(wb.rd), 32'(rd));
		check("wb.data", wb.data, expect_load(addr, lt));
	endtask

	// misaligned ops never reach the bus
	task automatic fault_and_check(input lsu_req_t req);
		lsu_wb_t wb;
		int      cycles;
		do_op(req, wb, cycles);
		check("cycles", 32'(cycles), 32'h2);
		check("wb.err", 32'(wb.err), 32'h1);
		check("wb.wen", 32'(wb.wen), 32'h0);
		check("wb.data", wb.data, 32'h0);
	endtask

	task automatic idle_after_reset();
		repeat (10) begin
			@(negedge clk);
			check("wb_valid_o", 32'(wb_valid_o), 32'h0);
			check("busy_o", 32'(busy_o), 32'h0);
		end
	endtask

	task automatic non_mem_ops();
		lsu_req_t    req;
		lsu_wb_t     wb;
		int          cycles;
		logic [31:0] addr;
		logic [31:0] rd;
		for (int i = 0; i < 4; i++) begin
			rand_bits(32, addr);
			rand_bits(5, rd);
			req     = make_req(addr, ~addr, LOAD_NONE, STORE_NONE, rd[4:0]);
			req.wen = (i != 3);
			do_op(req, wb, cycles);
			check("cycles", 32'(cycles), 32'h2);
			check("wb.wen", 32'(wb.wen), 32'(req.wen));
			check("wb.rd", 32'(wb.rd), rd);
			check("wb.data", wb.data, addr);
			check("wb.err", 32'(wb.err), 32'h0);
		end
	endtask

	task automatic word_store_load();
		logic [31:0] data;
		foreach (word_addrs[i]) begin
			rand_bits(32, data);
			store_and_check(word_addrs[i], data, STORE_SW);
		end
		foreach (word_addrs[i]) begin
			load_and_check(word_addrs[i], LOAD_LW, 5'(i + 1));
		end
	endtask

	task automatic byte_half_access();
		logic [31:0] data;
		// sign bits set in two lanes so both extensions show
		store_and_check(32'h100, 32'h80f7_7f08, STORE_SW);
		for (int off = 0; off < 4; off++) begin
			load_and_check(32'h100 + 32'(off), LOAD_LB, 5'd10);
			load_and_check(32'h100 + 32'(off), LOAD_LBU, 5'd11);
		end
		store_and_check(32'h104, 32'h0, STORE_SW);
		for (int off = 0; off < 4; off++) begin
			rand_bits(8, data);
			store_and_check(32'h104 + 32'(off), data, STORE_SB);
		end
		rand_bits(16, data);
		store_and_check(32'h106, data, STORE_SH);
		load_and_check(32'h104, LOAD_LW, 5'd12);
		for (int off = 0; off < 4; off += 2) begin
			load_and_check(32'h100 + 32'(off), LOAD_LH, 5'd13);
			load_and_check(32'h100 + 32'(off), LOAD_LHU, 5'd14);
			rand_bits(16, data);
			store_and_check(32'h104 + 32'(off), data, STORE_SH);
			load_and_check(32'h104 + 32'(off), LOAD_LH, 5'd15);
			load_and_check(32'h104 + 32'(off), LOAD_LHU, 5'd16);
		end
		for (int off = 0; off < 4; off++) begin
			load_and_check(32'h104 + 32'(off), LOAD_LB, 5'd17);
			load_and_check(32'h104 + 32'(off), LOAD_LBU, 5'd18);
		end
	endtask

	task automatic misaligned_faults();
		fault_and_check(make_req(32'h101, 32'h0, LOAD_LH, STORE_NONE, 5'd20));
		fault_and_check(make_req(32'h103, 32'h0, LOAD_LHU, STORE_NONE, 5'd20));
		fault_and_check(make_req(32'h102, 32'h0, LOAD_LW, STORE_NONE, 5'd21));
		fault_and_check(make_req(32'h101, 32'hdead_beef, LOAD_NONE, STORE_SH, 5'd22));
		fault_and_check(make_req(32'h103, 32'hdead_beef, LOAD_NONE, STORE_SW, 5'd23));
		fault_and_check(make_req(32'h102, 32'hdead_beef, LOAD_NONE, STORE_SW, 5'd23));
		load_and_check(32'h100, LOAD_LW, 5'd24);
		load_and_check(32'h104, LOAD_LW, 5'd25);
	endtask

	task automatic out_of_range_errors();
		lsu_wb_t wb;
		int      cycles;
		// these alias words 0 and 1 if the range check were missing
		do_op(make_req(32'(RAM_WORDS * 4), 32'h0, LOAD_LW, STORE_NONE, 5'd26), wb, cycles);
		check("wb.err", 32'(wb.err), 32'h1);
		check("wb.wen", 32'(wb.wen), 32'h0);
		check("wb.data", wb.data, 32'h0);
		do_op(make_req(32'(RAM_WORDS * 4 + 4), 32'h1234_5678, LOAD_NONE, STORE_SW, 5'd27),
			wb, cycles);
		check("wb.err", 32'(wb.err), 32'h1);
		check("wb.wen", 32'(wb.wen), 32'h0);
		do_op(make_req(32'h2000, 32'h0, LOAD_LBU, STORE_NONE, 5'd28), wb, cycles);
		check("wb.err", 32'(wb.err), 32'h1);
		check("wb.wen", 32'(wb.wen), 32'h0);
		foreach (word_addrs[i]) begin
			load_and_check(word_addrs[i], LOAD_LW, 5'd29);
		end
	endtask

	initial begin
		clk        = 1'b0;
		rstn       = 1'b0;
		op_valid_i = 1'b0;
		op_i       = '0;
		lfsr       = 16'd36;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rstn = 1'b1;

		idle_after_reset();
		non_mem_ops();
		word_store_load();
		byte_half_access();
		misaligned_faults();
		out_of_range_errors();

		repeat (2) @(negedge clk);
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- mem_stage.f
logic/lsu_pkg.sv
logic/store_align.sv
logic/load_extract.sv
logic/lsu_ctrl.sv
logic/axi_lite_ram.sv
logic/mem_stage_top.sv
tb/mem_stage_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the memory stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	-f mem_stage.f \
	--top-module mem_stage_tb \
	-Mdir obj_dir \
	-o mem_stage_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit $status
fi

./obj_dir/mem_stage_sim
status=$?
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit $status
fi

exit 0
